/* barrett_mod_n.sv */
//******************************
// Barrett reduction modulo n
// Uses the shared multiplier twice
// Request port out, response port in
//******************************
module barrett_mod_n (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  secp256k1_pkg::wide_t      i_dat,
  input  secp256k1_pkg::ctl_t       i_ctl,
  input  logic                      i_err,
  input  logic                      i_val,
  output logic                      o_rdy,
  output secp256k1_pkg::mult_in_t   o_mul_a,
  output secp256k1_pkg::mult_in_t   o_mul_b,
  output logic                      o_mul_val,
  input  logic                      i_mul_rdy,
  input  secp256k1_pkg::prod_t      i_mul_dat,
  input  logic                      i_mul_val,
  output secp256k1_pkg::operand_t   o_dat,
  output secp256k1_pkg::ctl_t       o_ctl,
  output logic                      o_err,
  output logic                      o_val,
  input  logic                      i_rdy
);

secp256k1_pkg::barrett_state_e state;

// Value being reduced
secp256k1_pkg::wide_t     x;
// Holds q3, then r, then the reduced result
secp256k1_pkg::mult_in_t  acc;
secp256k1_pkg::ctl_t      ctl_q;
logic                     err_q;

secp256k1_pkg::mult_in_t  n_ext;
secp256k1_pkg::mult_in_t  r1;
secp256k1_pkg::mult_in_t  r2;

assign n_ext = secp256k1_pkg::mult_in_t'(secp256k1_pkg::N_MOD);

// r is below 3n, two subtractions at most
assign r1 = (acc >= n_ext) ? acc - n_ext : acc;
assign r2 = (r1 >= n_ext) ? r1 - n_ext : r1;

assign o_rdy     = (state == secp256k1_pkg::IDLE);
assign o_mul_val = (state == secp256k1_pkg::MUL1) || (state == secp256k1_pkg::MUL2);

// First pass q1 * mu with q1 = x >> 255, second pass q3 * n
assign o_mul_a = (state == secp256k1_pkg::MUL2) ? acc : {1'b0, x[511:255]};
assign o_mul_b = (state == secp256k1_pkg::MUL2) ? n_ext :
                 secp256k1_pkg::mult_in_t'(secp256k1_pkg::BARRETT_MU);

assign o_val = (state == secp256k1_pkg::OUT);
assign o_dat = acc[255:0];
assign o_ctl = ctl_q;
assign o_err = err_q;

always_ff @(posedge i_clk) begin
  if (i_rst) begin
    state <= secp256k1_pkg::IDLE;
  end else begin
    case (state)
      secp256k1_pkg::IDLE:  if (i_val) state <= secp256k1_pkg::MUL1;
      secp256k1_pkg::MUL1:  if (i_mul_rdy) state <= secp256k1_pkg::WAIT1;
      secp256k1_pkg::WAIT1: if (i_mul_val) state <= secp256k1_pkg::MUL2;
      secp256k1_pkg::MUL2:  if (i_mul_rdy) state <= secp256k1_pkg::WAIT2;
      secp256k1_pkg::WAIT2: if (i_mul_val) state <= secp256k1_pkg::SUB;
      secp256k1_pkg::SUB:   state <= secp256k1_pkg::OUT;
      secp256k1_pkg::OUT:   if (i_rdy) state <= secp256k1_pkg::IDLE;
      default:              state <= secp256k1_pkg::IDLE;
    endcase
  end
end

always_ff @(posedge i_clk) begin
  case (state)
    secp256k1_pkg::IDLE: begin
      if (i_val) begin
        x     <= i_dat;
        ctl_q <= i_ctl;
        err_q <= i_err;
      end
    end
    // q3 is the product shifted right by 257
    secp256k1_pkg::WAIT1: if (i_mul_val) acc <= i_mul_dat[514:257];
    // Low bits of x - q3*n, with room for up to 3n
    secp256k1_pkg::WAIT2: if (i_mul_val) acc <= x[257:0] - i_mul_dat[257:0];
    secp256k1_pkg::SUB:   acc <= r2;
    default: ;
  endcase
end

endmodule

/* karatsuba_mult.sv */
//******************************
// Karatsuba-Ofman multiplier, one level
// 258 x 258 bits, three stages
// Single stall enable for all stages
//******************************
module karatsuba_mult (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  secp256k1_pkg::mult_in_t  i_a,
  input  secp256k1_pkg::mult_in_t  i_b,
  input  secp256k1_pkg::tag_t      i_tag,
  input  logic                     i_val,
  output logic                     o_rdy,
  output secp256k1_pkg::prod_t     o_dat,
  output secp256k1_pkg::tag_t      o_tag,
  output logic                     o_val,
  input  logic                     i_rdy
);

// Stage 1 registers, halves and half sums
logic [128:0]        s1_a_lo;
logic [128:0]        s1_a_hi;
logic [128:0]        s1_b_lo;
logic [128:0]        s1_b_hi;
logic [129:0]        s1_a_sum;
logic [129:0]        s1_b_sum;
secp256k1_pkg::tag_t s1_tag;
logic                s1_val;

// Stage 2 registers, the three sub-products
logic [257:0]        s2_z0;
logic [257:0]        s2_z2;
logic [259:0]        s2_z1;
secp256k1_pkg::tag_t s2_tag;
logic                s2_val;

// Stage 3 registers, full product
secp256k1_pkg::prod_t s3_dat;
secp256k1_pkg::tag_t  s3_tag;
logic                 s3_val;

logic         en;
logic [259:0] mid;

// Whole pipe holds while the output is blocked
assign en    = ~s3_val | i_rdy;
assign o_rdy = en;

// Middle term, (a0+a1)(b0+b1) - a0b0 - a1b1
assign mid = s2_z1 - {2'b00, s2_z0} - {2'b00, s2_z2};

always_ff @(posedge i_clk) begin
  if (i_rst) begin
    s1_val <= 1'b0;
    s2_val <= 1'b0;
    s3_val <= 1'b0;
  end else if (en) begin
    s1_val <= i_val;
    s2_val <= s1_val;
    s3_val <= s2_val;
  end
end

always_ff @(posedge i_clk) begin
  if (en) begin
    s1_a_lo  <= i_a[128:0];
    s1_a_hi  <= i_a[257:129];
    s1_b_lo  <= i_b[128:0];
    s1_b_hi  <= i_b[257:129];
    s1_a_sum <= 130'(i_a[128:0]) + 130'(i_a[257:129]);
    s1_b_sum <= 130'(i_b[128:0]) + 130'(i_b[257:129]);
    s1_tag   <= i_tag;
    s2_z0    <= 258'(s1_a_lo) * 258'(s1_b_lo);
    s2_z2    <= 258'(s1_a_hi) * 258'(s1_b_hi);
    s2_z1    <= 260'(s1_a_sum) * 260'(s1_b_sum);
    s2_tag   <= s1_tag;
    // z2 and z0 do not overlap, middle term lands at bit 129
    s3_dat   <= {s2_z2, s2_z0} + (secp256k1_pkg::prod_t'(mid) << 129);
    s3_tag   <= s2_tag;
  end
end

assign o_dat = s3_dat;
assign o_tag = s3_tag;
assign o_val = s3_val;

endmodule

/* mod_p_fold.sv */
//******************************
// Reduction modulo p
// Two folds with 2^256 = 2^32 + 977
// Final conditional subtract of p
//******************************
module mod_p_fold (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  secp256k1_pkg::wide_t      i_dat,
  input  secp256k1_pkg::ctl_t       i_ctl,
  input  logic                      i_err,
  input  logic                      i_val,
  output logic                      o_rdy,
  output secp256k1_pkg::operand_t   o_dat,
  output secp256k1_pkg::ctl_t       o_ctl,
  output logic                      o_err,
  output logic                      o_val,
  input  logic                      i_rdy
);

// First fold result is below 2^290
logic [289:0]            s1_t;
secp256k1_pkg::ctl_t     s1_ctl;
logic                    s1_err;
logic                    s1_val;

secp256k1_pkg::operand_t s2_dat;
secp256k1_pkg::ctl_t     s2_ctl;
logic                    s2_err;
logic                    s2_val;

logic         en;
logic [289:0] fold1;
logic [256:0] fold2;
logic [256:0] red;

assign en    = ~s2_val | i_rdy;
assign o_rdy = en;

// High half times FOLD_C added to the low half
assign fold1 = 290'(i_dat[255:0]) +
               290'(i_dat[511:256]) * 290'(secp256k1_pkg::FOLD_C);

// Carry is at most 34 bits, so this sum stays below 2p
assign fold2 = 257'(s1_t[255:0]) +
               257'(s1_t[289:256]) * 257'(secp256k1_pkg::FOLD_C);

assign red = (fold2 >= 257'(secp256k1_pkg::P_MOD)) ?
             fold2 - 257'(secp256k1_pkg::P_MOD) : fold2;

always_ff @(posedge i_clk) begin
  if (i_rst) begin
    s1_val <= 1'b0;
    s2_val <= 1'b0;
  end else if (en) begin
    s1_val <= i_val;
    s2_val <= s1_val;
  end
end

always_ff @(posedge i_clk) begin
  if (en) begin
    s1_t   <= fold1;
    s1_ctl <= i_ctl;
    s1_err <= i_err;
    // Fully reduced, top bit of red is always clear here
    s2_dat <= red[255:0];
    s2_ctl <= s1_ctl;
    s2_err <= s1_err;
  end
end

assign o_dat = s2_dat;
assign o_ctl = s2_ctl;
assign o_err = s2_err;
assign o_val = s2_val;

endmodule

/* mult_mod_decode.sv */
//******************************
// Multiplier input selection
// External operands or Barrett requests
// Holds input while a mod n op is open
//******************************
module mult_mod_decode (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  secp256k1_pkg::operand_t   i_dat_a,
  input  secp256k1_pkg::operand_t   i_dat_b,
  input  secp256k1_pkg::mult_cmd_e  i_cmd,
  input  secp256k1_pkg::ctl_t       i_ctl,
  input  logic                      i_err,
  input  logic                      i_val,
  output logic                      o_rdy,
  output secp256k1_pkg::mult_in_t   o_m_a,
  output secp256k1_pkg::mult_in_t   o_m_b,
  output secp256k1_pkg::tag_t       o_m_tag,
  output logic                      o_m_val,
  input  logic                      i_m_rdy,
  input  secp256k1_pkg::mult_in_t   i_brt_a,
  input  secp256k1_pkg::mult_in_t   i_brt_b,
  input  logic                      i_brt_val,
  output logic                      o_brt_rdy,
  input  logic                      i_nr_done
);

localparam int LAT = secp256k1_pkg::MULT_LATENCY;

logic                     live;
logic                     wait_n;
logic [LAT-1:0]           drain;
logic                     owned;
logic                     accept;
secp256k1_pkg::mult_cmd_e cmd;
logic                     err;

// Multiplier belongs to Barrett once older items have left the pipeline
assign owned  = drain[LAT-1];
// Input side opens one cycle after reset and closes during mod n
assign accept = live & ~wait_n;
assign o_rdy  = i_m_rdy & accept;

// Reserved command runs as mod p and is flagged
assign cmd = (i_cmd == secp256k1_pkg::CMD_RSVD) ? secp256k1_pkg::CMD_MOD_P : i_cmd;
assign err = i_err | (i_cmd == secp256k1_pkg::CMD_RSVD);

always_comb begin
  if (owned) begin
    o_m_a     = i_brt_a;
    o_m_b     = i_brt_b;
    o_m_val   = i_brt_val;
    o_brt_rdy = i_m_rdy;
    // Marked so the product goes back to Barrett
    o_m_tag   = {1'b1, 1'b0, secp256k1_pkg::CMD_MOD_N, secp256k1_pkg::ctl_t'(0)};
  end else begin
    o_m_a     = {2'b00, i_dat_a};
    o_m_b     = {2'b00, i_dat_b};
    o_m_val   = i_val & accept;
    o_brt_rdy = 1'b0;
    o_m_tag   = {1'b0, err, cmd, i_ctl};
  end
end

always_ff @(posedge i_clk) begin
  if (i_rst) begin
    live   <= 1'b0;
    wait_n <= 1'b0;
    drain  <= '0;
  end else begin
    live <= 1'b1;
    // Count pipeline advances since the mod n op went in
    if (i_m_rdy) begin
      drain <= {drain[LAT-2:0], wait_n};
    end
    if (i_val && o_rdy && cmd == secp256k1_pkg::CMD_MOD_N) begin
      wait_n <= 1'b1;
    end
    // Mod n result left on the output
    if (i_nr_done) begin
      wait_n <= 1'b0;
      drain  <= '0;
    end
  end
end

endmodule

/* mult_mod_result.sv */
//******************************
// Multiplier output routing
// Fold, Barrett input or Barrett response
// Output merge, mod p stream first
//******************************
module mult_mod_result (
  input  secp256k1_pkg::prod_t      i_p_dat,
  input  secp256k1_pkg::tag_t       i_p_tag,
  input  logic                      i_p_val,
  output logic                      o_p_rdy,
  output secp256k1_pkg::wide_t      o_fold_dat,
  output logic                      o_fold_val,
  input  logic                      i_fold_rdy,
  output logic                      o_brt_in_val,
  input  logic                      i_brt_in_rdy,
  output secp256k1_pkg::prod_t      o_rsp_dat,
  output logic                      o_rsp_val,
  input  secp256k1_pkg::operand_t   i_pr_dat,
  input  secp256k1_pkg::ctl_t       i_pr_ctl,
  input  logic                      i_pr_err,
  input  logic                      i_pr_val,
  output logic                      o_pr_rdy,
  input  secp256k1_pkg::operand_t   i_nr_dat,
  input  secp256k1_pkg::ctl_t       i_nr_ctl,
  input  logic                      i_nr_err,
  input  logic                      i_nr_val,
  output logic                      o_nr_rdy,
  output secp256k1_pkg::operand_t   o_dat,
  output secp256k1_pkg::ctl_t       o_ctl,
  output logic                      o_err,
  output logic                      o_val,
  input  logic                      i_rdy
);

logic                     brt;
logic                     to_n;
secp256k1_pkg::mult_cmd_e cmd;

// Tag decode, done once
assign brt  = i_p_tag[secp256k1_pkg::TAG_BRT_BIT];
assign cmd  = secp256k1_pkg::mult_cmd_e'(i_p_tag[secp256k1_pkg::TAG_CMD_LSB +: 2]);
assign to_n = ~brt & (cmd == secp256k1_pkg::CMD_MOD_N);

// Shift command reduces only the upper half
assign o_fold_dat = (cmd == secp256k1_pkg::CMD_SHIFT_P) ?
                    {256'd0, i_p_dat[511:256]} : i_p_dat[511:0];
assign o_fold_val   = i_p_val & ~brt & ~to_n;
assign o_brt_in_val = i_p_val & to_n;

// Barrett is always waiting when its response arrives
assign o_rsp_dat = i_p_dat;
assign o_rsp_val = i_p_val & brt;

always_comb begin
  if (brt) begin
    o_p_rdy = 1'b1;
  end else if (to_n) begin
    o_p_rdy = i_brt_in_rdy;
  end else begin
    o_p_rdy = i_fold_rdy;
  end
end

// Older mod p items always drain ahead of the mod n result
assign o_val    = i_pr_val | i_nr_val;
assign o_dat    = i_pr_val ? i_pr_dat : i_nr_dat;
assign o_ctl    = i_pr_val ? i_pr_ctl : i_nr_ctl;
assign o_err    = i_pr_val ? i_pr_err : i_nr_err;
assign o_pr_rdy = i_rdy;
assign o_nr_rdy = i_rdy & ~i_pr_val;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the secp256k1_mult_mod testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sources.f --top-module tb_secp256k1_mult_mod -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_secp256k1_mult_mod)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^=== PASS ===$"; then
  exit 0
fi
exit 1

/* secp256k1_mult_mod.sv */
//******************************
// secp256k1 multiply and reduce, top
// Decode, Karatsuba multiplier, result
// Mod p fold and Barrett mod n reducers
//******************************
module secp256k1_mult_mod (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  secp256k1_pkg::operand_t   i_dat_a,
  input  secp256k1_pkg::operand_t   i_dat_b,
  input  secp256k1_pkg::mult_cmd_e  i_cmd,
  input  secp256k1_pkg::ctl_t       i_ctl,
  input  logic                      i_err,
  input  logic                      i_val,
  output logic                      o_rdy,
  output secp256k1_pkg::operand_t   o_dat,
  output secp256k1_pkg::ctl_t       o_ctl,
  output logic                      o_err,
  output logic                      o_val,
  input  logic                      i_rdy
);

localparam int CB = secp256k1_pkg::CTL_BITS;

// Decode to multiplier
secp256k1_pkg::mult_in_t m_a, m_b;
secp256k1_pkg::tag_t     m_tag;
logic                    m_val, m_rdy;

// Multiplier to result
secp256k1_pkg::prod_t    p_dat;
secp256k1_pkg::tag_t     p_tag;
logic                    p_val, p_rdy;

// Barrett request and response
secp256k1_pkg::mult_in_t brt_req_a, brt_req_b;
logic                    brt_req_val, brt_req_rdy;
secp256k1_pkg::prod_t    brt_rsp_dat;
logic                    brt_rsp_val;

// Reducer inputs, shared data bus
secp256k1_pkg::wide_t    red_dat;
logic                    fold_val, fold_rdy;
logic                    brt_in_val, brt_in_rdy;

// Reducer outputs
secp256k1_pkg::operand_t pr_dat, nr_dat;
secp256k1_pkg::ctl_t     pr_ctl, nr_ctl;
logic                    pr_err, pr_val, pr_rdy;
logic                    nr_err, nr_val, nr_rdy;

mult_mod_decode u_decode (
  .i_clk, .i_rst, .i_dat_a, .i_dat_b, .i_cmd, .i_ctl, .i_err, .i_val, .o_rdy,
  .o_m_a (m_a), .o_m_b (m_b), .o_m_tag (m_tag), .o_m_val (m_val), .i_m_rdy (m_rdy),
  .i_brt_a (brt_req_a), .i_brt_b (brt_req_b), .i_brt_val (brt_req_val),
  .o_brt_rdy (brt_req_rdy), .i_nr_done (nr_val & nr_rdy)
);

karatsuba_mult u_mult (
  .i_clk, .i_rst, .i_a (m_a), .i_b (m_b), .i_tag (m_tag), .i_val (m_val),
  .o_rdy (m_rdy), .o_dat (p_dat), .o_tag (p_tag), .o_val (p_val), .i_rdy (p_rdy)
);

mult_mod_result u_result (
  .i_p_dat (p_dat), .i_p_tag (p_tag), .i_p_val (p_val), .o_p_rdy (p_rdy),
  .o_fold_dat (red_dat), .o_fold_val (fold_val), .i_fold_rdy (fold_rdy),
  .o_brt_in_val (brt_in_val), .i_brt_in_rdy (brt_in_rdy),
  .o_rsp_dat (brt_rsp_dat), .o_rsp_val (brt_rsp_val),
  .i_pr_dat (pr_dat), .i_pr_ctl (pr_ctl), .i_pr_err (pr_err), .i_pr_val (pr_val),
  .o_pr_rdy (pr_rdy), .i_nr_dat (nr_dat), .i_nr_ctl (nr_ctl), .i_nr_err (nr_err),
  .i_nr_val (nr_val), .o_nr_rdy (nr_rdy), .o_dat, .o_ctl, .o_err, .o_val, .i_rdy
);

mod_p_fold u_fold (
  .i_clk, .i_rst, .i_dat (red_dat), .i_ctl (p_tag[secp256k1_pkg::TAG_CTL_LSB +: CB]),
  .i_err (p_tag[secp256k1_pkg::TAG_ERR_BIT]), .i_val (fold_val), .o_rdy (fold_rdy),
  .o_dat (pr_dat), .o_ctl (pr_ctl), .o_err (pr_err), .o_val (pr_val), .i_rdy (pr_rdy)
);

barrett_mod_n u_barrett (
  .i_clk, .i_rst, .i_dat (red_dat), .i_ctl (p_tag[secp256k1_pkg::TAG_CTL_LSB +: CB]),
  .i_err (p_tag[secp256k1_pkg::TAG_ERR_BIT]), .i_val (brt_in_val), .o_rdy (brt_in_rdy),
  .o_mul_a (brt_req_a), .o_mul_b (brt_req_b), .o_mul_val (brt_req_val),
  .i_mul_rdy (brt_req_rdy), .i_mul_dat (brt_rsp_dat), .i_mul_val (brt_rsp_val),
  .o_dat (nr_dat), .o_ctl (nr_ctl), .o_err (nr_err), .o_val (nr_val), .i_rdy (nr_rdy)
);

endmodule

/* secp256k1_mult_mod_asserts.sv */
//******************************
// Handshake and reset assertions
// Bound to the multiplier top level
//******************************
module secp256k1_mult_mod_asserts (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  secp256k1_pkg::mult_cmd_e  i_cmd,
  input  secp256k1_pkg::ctl_t       i_ctl,
  input  logic                      i_val,
  input  logic                      o_rdy,
  input  secp256k1_pkg::operand_t   o_dat,
  input  secp256k1_pkg::ctl_t       o_ctl,
  input  logic                      o_err,
  input  logic                      o_val,
  input  logic                      i_rdy
);
timeunit 1ns;
timeprecision 1ps;

// Reset seen on the previous edge
logic rst_q = 1'b0;
// Mod n op accepted and its result not yet taken
logic n_open;
// Tag of the open mod n op
secp256k1_pkg::ctl_t n_ctl;

always_ff @(posedge i_clk) begin
  rst_q <= i_rst;
end

// Opened by the mod n input transfer, closed by the output transfer with its tag
always_ff @(posedge i_clk) begin
  if (i_rst) begin
    n_open <= 1'b0;
    n_ctl  <= '0;
  end else if (i_val && o_rdy && i_cmd == secp256k1_pkg::CMD_MOD_N) begin
    n_open <= 1'b1;
    n_ctl  <= i_ctl;
  end else if (o_val && i_rdy && o_ctl == n_ctl) begin
    n_open <= 1'b0;
  end
end

// Both handshakes idle in the cycle after reset
a_reset_idle: assert property (@(posedge i_clk) rst_q |-> (!o_val && !o_rdy))
  else $error("o_val or o_rdy high right after reset");

// Result held steady while the sink stalls
a_out_stable: assert property (@(posedge i_clk) disable iff (i_rst)
  (o_val && !i_rdy) |=> (o_val && $stable(o_dat) && $stable(o_ctl) && $stable(o_err)))
  else $error("Output changed while stalled");

// Input side closed for the whole mod n operation
a_mod_n_lock: assert property (@(posedge i_clk) disable iff (i_rst) n_open |-> !o_rdy)
  else $error("o_rdy high while a mod n result is pending");

endmodule

bind secp256k1_mult_mod secp256k1_mult_mod_asserts u_asserts (
  .i_clk, .i_rst, .i_cmd, .i_ctl, .i_val, .o_rdy, .o_dat, .o_ctl, .o_err, .o_val, .i_rdy
);

/* secp256k1_pkg.sv */
//******************************
// secp256k1 multiplier constants
// Width typedefs and tag layout
// Command and Barrett state enums
//******************************
package secp256k1_pkg;

// Tag width for the user control field
localparam int CTL_BITS = 8;

// Multiplier pipeline depth in cycles
localparam int MULT_LATENCY = 3;

// Internal tag layout is {brt, err, cmd[1:0], ctl}
localparam int TAG_CTL_LSB = 0;
localparam int TAG_CMD_LSB = CTL_BITS;
localparam int TAG_ERR_BIT = CTL_BITS + 2;
localparam int TAG_BRT_BIT = CTL_BITS + 3;
localparam int TAG_BITS    = CTL_BITS + 4;

typedef logic [255:0]          operand_t;
typedef logic [257:0]          mult_in_t;
typedef logic [515:0]          prod_t;
typedef logic [511:0]          wide_t;
typedef logic [CTL_BITS-1:0]   ctl_t;
typedef logic [TAG_BITS-1:0]   tag_t;

// Field prime, 2^256 - 2^32 - 977
localparam operand_t P_MOD =
  256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_FFFFFC2F;
// Group order
localparam operand_t N_MOD =
  256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_BAAEDCE6_AF48A03B_BFD25E8C_D0364141;
// floor(2^512 / n)
localparam logic [256:0] BARRETT_MU =
  257'h1_00000000_00000000_00000000_00000001_45512319_50B75FC4_402DA173_2FC9BEC0;
// 2^256 mod p
localparam logic [32:0] FOLD_C = 33'h1_0000_03D1;

typedef enum logic [1:0] {
  CMD_MOD_P   = 2'd0,
  CMD_MOD_N   = 2'd1,
  CMD_SHIFT_P = 2'd2,
  CMD_RSVD    = 2'd3
} mult_cmd_e;

typedef enum logic [2:0] {IDLE, MUL1, WAIT1, MUL2, WAIT2, SUB, OUT} barrett_state_e;

endpackage

/* sources.f */
secp256k1_pkg.sv
mult_mod_decode.sv
karatsuba_mult.sv
mod_p_fold.sv
barrett_mod_n.sv
mult_mod_result.sv
secp256k1_mult_mod.sv
secp256k1_mult_mod_asserts.sv
tb_secp256k1_mult_mod.sv

/* tb_secp256k1_mult_mod.sv */
//******************************
// Testbench for secp256k1_mult_mod
// Directed tests and wide reference model
// Scoreboard, clock, reset, watchdog
//******************************
module tb_secp256k1_mult_mod;
timeunit 1ns;
timeprecision 1ps;

localparam int CLK_HALF    = 2;
localparam int NUM_OPS     = 40;
localparam int WATCHDOG_NS = NUM_OPS * 200 * 2 * CLK_HALF;
localparam logic [31:0] SEED = 32'hf27643f2;

// Reference moduli, 512 bits wide for the model
localparam logic [511:0] P_REF = (512'd1 << 256) - (512'd1 << 32) - 512'd977;
localparam logic [511:0] N_REF =
  512'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_BAAEDCE6_AF48A03B_BFD25E8C_D0364141;

logic                     i_clk = 1'b0;
logic                     i_rst;
secp256k1_pkg::operand_t  i_dat_a;
secp256k1_pkg::operand_t  i_dat_b;
secp256k1_pkg::mult_cmd_e i_cmd;
secp256k1_pkg::ctl_t      i_ctl;
logic                     i_err;
logic                     i_val;
logic                     o_rdy;
secp256k1_pkg::operand_t  o_dat;
secp256k1_pkg::ctl_t      o_ctl;
logic                     o_err;
logic                     o_val;
logic                     i_rdy = 1'b1;

// Expected results in issue order
secp256k1_pkg::operand_t  exp_dat[$];
secp256k1_pkg::ctl_t      exp_ctl[$];
logic                     exp_err[$];

int          checks = 0;
int          errors = 0;
int          cyc = 0;
int          in_cyc;
int          out_cyc;
logic        rdy_rand = 1'b0;
logic        watch_lock = 1'b0;
logic [7:0]  tag_cnt = 8'd0;

secp256k1_mult_mod u_dut (
  .i_clk, .i_rst, .i_dat_a, .i_dat_b, .i_cmd, .i_ctl, .i_err, .i_val, .o_rdy,
  .o_dat, .o_ctl, .o_err, .o_val, .i_rdy
);

always #CLK_HALF i_clk = ~i_clk;

// Rising edge count, transfers are stamped with it
always @(posedge i_clk) cyc <= cyc + 1;

// Sink ready, random during the mixed burst
always @(posedge i_clk) i_rdy <= rdy_rand ? 1'($urandom % 2) : 1'b1;

function automatic secp256k1_pkg::operand_t rand_operand();
  secp256k1_pkg::operand_t r;
  int i;
  r = '0;
  for (i = 0; i < 8; i++) begin
    r = {r[223:0], $urandom()};
  end
  return r;
endfunction

// Full product, then the reduction chosen by the command
function automatic secp256k1_pkg::operand_t expected_value(
  input secp256k1_pkg::operand_t a, input secp256k1_pkg::operand_t b, input logic [1:0] cmd);
  logic [511:0] prod;
  logic [511:0] res;
  prod = 512'(a) * 512'(b);
  case (cmd)
    2'd1:    res = prod % N_REF;
    2'd2:    res = (prod >> 256) % P_REF;
    default: res = prod % P_REF;
  endcase
  return res[255:0];
endfunction

// Output side, checked half a cycle before each edge
always @(negedge i_clk) begin : monitor
  secp256k1_pkg::operand_t want_dat;
  secp256k1_pkg::ctl_t     want_ctl;
  logic                    want_err;
  if (watch_lock && exp_dat.size() != 0 && o_rdy) begin
    errors++;
    $display("CHECK FAILED at %0t: o_rdy high before the mod n result was taken", $time);
  end
  if (!i_rst && o_val && i_rdy) begin
    out_cyc = cyc + 1;
    if (exp_dat.size() == 0) begin
      errors++;
      $display("Unexpected result at %0t with no operation outstanding", $time);
    end else begin
      want_dat = exp_dat.pop_front();
      want_ctl = exp_ctl.pop_front();
      want_err = exp_err.pop_front();
      checks++;
      if (o_dat !== want_dat || o_ctl !== want_ctl || o_err !== want_err) begin
        errors++;
        $display("CHECK FAILED at %0t: tag %h err %b data %h, want tag %h err %b data %h",
                 $time, o_ctl, o_err, o_dat, want_ctl, want_err, want_dat);
      end
    end
  end
end

// Called on a rising edge, returns on the transfer edge with i_val still high
task automatic send_op(input secp256k1_pkg::operand_t a, input secp256k1_pkg::operand_t b,
                       input logic [1:0] cmd, input logic err);
  i_dat_a <= a;
  i_dat_b <= b;
  i_cmd   <= secp256k1_pkg::mult_cmd_e'(cmd);
  i_ctl   <= tag_cnt;
  i_err   <= err;
  i_val   <= 1'b1;
  @(negedge i_clk);
  while (!o_rdy) @(negedge i_clk);
  exp_dat.push_back(expected_value(a, b, cmd));
  exp_ctl.push_back(tag_cnt);
  // Reserved command comes back flagged
  exp_err.push_back(err | (cmd == 2'd3));
  in_cyc = cyc + 1;
  tag_cnt++;
  @(posedge i_clk);
endtask

task automatic wait_drain();
  while (exp_dat.size() != 0) @(negedge i_clk);
  @(posedge i_clk);
endtask

// One operation alone in the pipeline, optional exact latency
task automatic single_op(input secp256k1_pkg::operand_t a, input secp256k1_pkg::operand_t b,
                         input logic [1:0] cmd, input logic err, input int lat);
  send_op(a, b, cmd, err);
  i_val <= 1'b0;
  watch_lock = (cmd == 2'd1);
  if (watch_lock) checks++;
  wait_drain();
  watch_lock = 1'b0;
  if (lat > 0) begin
    checks++;
    if (out_cyc - in_cyc != lat) begin
      errors++;
      $display("CHECK FAILED at %0t: latency %0d cycles, want %0d", $time, out_cyc - in_cyc, lat);
    end
  end
endtask

task automatic report_test(input string name, input int err0);
  if (errors == err0) begin
    $display("%s: ok", name);
  end else begin
    $display("%s: %0d errors", name, errors - err0);
  end
endtask

task automatic mod_p_test();
  int err0;
  int i;
  err0 = errors;
  single_op('0, rand_operand(), 2'd0, 1'b0, 5);
  single_op(256'd1, rand_operand(), 2'd0, 1'b0, 5);
  single_op(P_REF[255:0] - 256'd1, P_REF[255:0] - 256'd1, 2'd0, 1'b0, 5);
  single_op({256{1'b1}}, {256{1'b1}}, 2'd0, 1'b0, 5);
  for (i = 0; i < 6; i++) begin
    single_op(rand_operand(), rand_operand(), 2'd0, 1'b0, 5);
  end
  report_test("mod p", err0);
endtask

task automatic mod_n_test();
  int err0;
  int i;
  err0 = errors;
  single_op(N_REF[255:0] - 256'd1, N_REF[255:0] - 256'd1, 2'd1, 1'b0, 0);
  for (i = 0; i < 5; i++) begin
    single_op(rand_operand(), rand_operand(), 2'd1, 1'b0, 0);
  end
  report_test("mod n", err0);
endtask

task automatic shift_test();
  int err0;
  int i;
  err0 = errors;
  for (i = 0; i < 5; i++) begin
    single_op(rand_operand(), rand_operand(), 2'd2, 1'b0, 5);
  end
  report_test("shift mod p", err0);
endtask

// Back to back commands 0 to 2 with a stalling sink
task automatic mixed_test();
  int err0;
  int i;
  err0 = errors;
  rdy_rand <= 1'b1;
  for (i = 0; i < 16; i++) begin
    send_op(rand_operand(), rand_operand(), 2'($urandom % 3), 1'b0);
  end
  i_val <= 1'b0;
  wait_drain();
  rdy_rand <= 1'b0;
  report_test("mixed stream", err0);
endtask

task automatic error_test();
  int err0;
  err0 = errors;
  single_op(rand_operand(), rand_operand(), 2'd0, 1'b1, 5);
  single_op(rand_operand(), rand_operand(), 2'd1, 1'b1, 0);
  single_op(rand_operand(), rand_operand(), 2'd2, 1'b1, 5);
  single_op(rand_operand(), rand_operand(), 2'd3, 1'b0, 5);
  report_test("error flag", err0);
endtask

initial begin
  void'($urandom(SEED));
  i_rst   <= 1'b1;
  i_dat_a <= '0;
  i_dat_b <= '0;
  i_cmd   <= secp256k1_pkg::CMD_MOD_P;
  i_ctl   <= '0;
  i_err   <= 1'b0;
  i_val   <= 1'b0;
  repeat (2) @(posedge i_clk);
  i_rst <= 1'b0;
  @(posedge i_clk);
  mod_p_test();
  mod_n_test();
  shift_test();
  mixed_test();
  error_test();
  $display("Summary: %0d checks, %0d errors", checks, errors);
  if (errors == 0) begin
    $display("=== PASS ===");
  end else begin
    $display("=== FAIL ===");
  end
  $finish;
end

// Bound on run time, about 200 cycles per operation
initial begin
  #(WATCHDOG_NS);
  $display("Watchdog expired at %0t, the DUT stopped responding", $time);
  $display("=== FAIL ===");
  $finish;
end

endmodule
